//--- tm1638_pkg.sv
package tm1638_pkg;

    // ------------------------------------------------
    // Panel geometry

    localparam int W_TM_DIGIT = 8;
    localparam int W_TM_LED   = 8;
    localparam int W_TM_KEY   = 8;
    localparam int W_SEG      = 8;                  // One segment byte, hgfedcba
    localparam int W_TOTAL    = 4 * W_TM_DIGIT;     // One hex digit per nibble
    localparam int KEY_BRIGHT = 7;                  // Brightness step key

    // ------------------------------------------------
    // Serial timing

    localparam int SIO_HALF_CYCLES = 4;
    localparam int W_SIO_HALF      = $clog2(SIO_HALF_CYCLES);

    // Stb high time between windows, also the wait after the read command
    localparam int STB_GAP_CYCLES = 2 * SIO_HALF_CYCLES;
    localparam int W_STB_GAP      = $clog2(STB_GAP_CYCLES);

    // Frame layout
    localparam int N_DATA_BYTES = 2 * W_TM_DIGIT;   // Segment and LED byte per digit
    localparam int N_KEY_BYTES  = W_TM_KEY / 2;     // Two keys per scan byte
    localparam int W_BYTE_IDX   = $clog2(N_DATA_BYTES + 1);

    // ------------------------------------------------
    // Command bytes

    localparam logic [7:0] CMD_WRITE_AUTO = 8'h40;
    localparam logic [7:0] CMD_ADDR0      = 8'hC0;
    localparam logic [7:0] CMD_DISPLAY    = 8'h88;  // Bit 3 is display on
    localparam logic [7:0] CMD_READ_KEYS  = 8'h42;

    // ------------------------------------------------
    // Shared types

    typedef logic [W_TM_KEY-1:0] tm_keys_t;         // Bit k set while key k is held

    typedef logic [W_TM_DIGIT-1:0][W_SEG-1:0] tm_seg_t;  // Index 0 is the leftmost digit

    typedef struct packed {
        tm_seg_t             seg;
        logic [W_TM_LED-1:0] led;
    } tm_display_t;

    typedef struct packed {
        logic       display_on;
        logic [2:0] brightness;
    } tm_cfg_t;

    localparam tm_cfg_t CFG_RESET = '{display_on: 1'b1, brightness: 3'd7};

endpackage

//--- tm1638_serial.sv
`timescale 1ns/1ps

module tm1638_serial (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic [7:0] i_tx_byte,
    input  logic       i_read_mode,
    input  logic       i_tm_dio,
    output logic       o_done,
    output logic [7:0] o_rx_byte,
    output logic       o_tm_clk,
    output logic       o_tm_dio,
    output logic       o_tm_dio_oe
);
    import tm1638_pkg::*;

    logic                  busy;
    logic                  sclk;        // Serial clock level, idles high
    logic [W_SIO_HALF-1:0] half_cnt;
    logic [2:0]            bit_cnt;
    logic [7:0]            tx_shift;
    logic [7:0]            rx_shift;
    logic                  half_end;
    logic                  accept;

    assign accept   = i_start && !busy;
    assign half_end = busy && (half_cnt == W_SIO_HALF'(SIO_HALF_CYCLES - 1));

    // ------------------------------------------------
    // Half period and bit counting

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy     <= 1'b0;
            sclk     <= 1'b1;
            half_cnt <= '0;
            bit_cnt  <= '0;
        end else if (accept) begin
            busy     <= 1'b1;
            sclk     <= 1'b0;               // First low half, bit 0 on the line
            half_cnt <= '0;
            bit_cnt  <= '0;
        end else if (busy) begin
            half_cnt <= half_cnt + 1'b1;
            if (half_end) begin
                half_cnt <= '0;
                if (!sclk) begin
                    sclk <= 1'b1;           // Rising edge, both sides sample here
                end else if (bit_cnt == 3'd7) begin
                    busy <= 1'b0;           // Clock stays high after the last bit
                end else begin
                    sclk    <= 1'b0;
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------
    // Shift registers, LSB first

    always_ff @(posedge i_clk) begin
        if (accept) begin
            tx_shift <= i_tx_byte;
        end else if (half_end && sclk) begin
            tx_shift <= {1'b0, tx_shift[7:1]};  // Next bit while clock is low
        end

        if (half_end && !sclk) begin
            rx_shift <= {i_tm_dio, rx_shift[7:1]};
        end
    end

    // Last high half ends here, the final read bit is already in
    assign o_done    = half_end && sclk && (bit_cnt == 3'd7);
    assign o_rx_byte = rx_shift;

    assign o_tm_clk    = sclk;
    assign o_tm_dio    = busy ? tx_shift[0] : 1'b1;
    assign o_tm_dio_oe = busy && !i_read_mode;  // Panel owns the line in a read

endmodule

//--- tm1638_controller.sv
`timescale 1ns/1ps

module tm1638_controller (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  tm1638_pkg::tm_display_t i_display,
    input  tm1638_pkg::tm_cfg_t     i_cfg,
    input  logic                    i_tm_dio,
    output tm1638_pkg::tm_keys_t    o_keys,
    output logic                    o_keys_valid,
    output logic                    o_tm_stb,
    output logic                    o_tm_clk,
    output logic                    o_tm_dio,
    output logic                    o_tm_dio_oe
);
    import tm1638_pkg::*;

    typedef enum logic [1:0] {S_GAP, S_SEND, S_BUSY, S_TWAIT} state_t;

    // Windows in frame order
    typedef enum logic [1:0] {WIN_MODE, WIN_DATA, WIN_CTRL, WIN_KEYS} win_t;

    state_t                state;
    win_t                  win;
    logic [W_BYTE_IDX-1:0] byte_idx;
    logic [W_BYTE_IDX-1:0] last_idx;
    logic [W_STB_GAP-1:0]  cnt;
    logic                  cnt_end;

    tm_display_t disp_q;
    tm_keys_t    key_acc;
    tm_keys_t    key_next;
    logic [3:0]  addr;
    logic [1:0]  rd_idx;

    logic       ser_start;
    logic       ser_done;
    logic       read_mode;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;

    assign cnt_end   = (cnt == W_STB_GAP'(STB_GAP_CYCLES - 1));
    assign ser_start = (state == S_SEND);
    assign read_mode = (win == WIN_KEYS) && (byte_idx != '0);

    // ------------------------------------------------
    // Outgoing byte and key assembly

    always_comb begin
        addr   = 4'(byte_idx - 1'b1);       // Byte 0 of a window is its command
        rd_idx = 2'(byte_idx - 1'b1);

        case (win)
            WIN_MODE: tx_byte = CMD_WRITE_AUTO;
            WIN_DATA: begin
                if (byte_idx == '0)
                    tx_byte = CMD_ADDR0;
                else if (addr[0])
                    tx_byte = {7'b0, disp_q.led[addr[3:1]]};  // LED at odd address
                else
                    tx_byte = disp_q.seg[addr[3:1]];
            end
            // Display on and brightness fill the low nibble
            WIN_CTRL: tx_byte = {CMD_DISPLAY[7:4], i_cfg.display_on, i_cfg.brightness};
            default:  tx_byte = CMD_READ_KEYS;  // Ignored once the line is released
        endcase

        case (win)
            WIN_DATA: last_idx = W_BYTE_IDX'(N_DATA_BYTES);
            WIN_KEYS: last_idx = W_BYTE_IDX'(N_KEY_BYTES);
            default:  last_idx = '0;
        endcase

        key_next                   = key_acc;
        key_next[{rd_idx, 1'b0}]   = rx_byte[0];
        key_next[{rd_idx, 1'b1}]   = rx_byte[4];
    end

    // ------------------------------------------------
    // Frame sequencer

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= S_GAP;
            win          <= WIN_MODE;
            byte_idx     <= '0;
            cnt          <= '0;
            o_tm_stb     <= 1'b1;
            o_keys       <= '0;
            o_keys_valid <= 1'b0;
        end else begin
            o_keys_valid <= 1'b0;
            case (state)
                S_GAP, S_TWAIT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt_end) begin
                        cnt      <= '0;
                        o_tm_stb <= 1'b0;
                        state    <= S_SEND;
                    end
                end
                S_SEND: state <= S_BUSY;
                S_BUSY: begin
                    if (ser_done) begin
                        if (byte_idx == last_idx) begin
                            o_tm_stb <= 1'b1;               // Window closes
                            byte_idx <= '0;
                            win      <= win_t'(win + 1'b1);
                            state    <= S_GAP;
                            if (win == WIN_KEYS) begin
                                o_keys       <= key_next;
                                o_keys_valid <= 1'b1;       // End of frame
                            end
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            // Panel needs a pause between read command and first read
                            if (win == WIN_KEYS && byte_idx == '0)
                                state <= S_TWAIT;
                            else
                                state <= S_SEND;
                        end
                    end
                end
                default: state <= S_GAP;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_GAP && cnt_end && win == WIN_MODE)
            disp_q <= i_display;                            // Frame start
        if (state == S_BUSY && ser_done && read_mode)
            key_acc <= key_next;
    end

    tm1638_serial u_serial (
        .i_clk       ( i_clk       ),
        .i_rst_n     ( i_rst_n     ),
        .i_start     ( ser_start   ),
        .i_tx_byte   ( tx_byte     ),
        .i_read_mode ( read_mode   ),
        .i_tm_dio    ( i_tm_dio    ),
        .o_done      ( ser_done    ),
        .o_rx_byte   ( rx_byte     ),
        .o_tm_clk    ( o_tm_clk    ),
        .o_tm_dio    ( o_tm_dio    ),
        .o_tm_dio_oe ( o_tm_dio_oe )
    );

endmodule

//--- tm1638_config.sv
`timescale 1ns/1ps

module tm1638_config (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  tm1638_pkg::tm_keys_t i_keys,
    input  logic                 i_keys_valid,
    output tm1638_pkg::tm_cfg_t  o_cfg
);
    import tm1638_pkg::*;

    logic key_bright_q;     // Key 7 as seen in the previous frame

    // ------------------------------------------------
    // Brightness stepping

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            key_bright_q <= 1'b0;
            o_cfg        <= CFG_RESET;
        end else if (i_keys_valid) begin
            key_bright_q <= i_keys[KEY_BRIGHT];
            if (i_keys[KEY_BRIGHT] && !key_bright_q) begin
                o_cfg.brightness <= o_cfg.brightness + 1'b1;    // 7 wraps to 0
            end
        end
    end

endmodule

//--- seg7_hex_encoder.sv
`timescale 1ns/1ps

module seg7_hex_encoder (
    input  logic [tm1638_pkg::W_TOTAL-1:0] i_value,
    output tm1638_pkg::tm_seg_t            o_seg
);
    import tm1638_pkg::*;

    // Bit 0 is segment a, dot (h) always off
    function automatic logic [W_SEG-1:0] hex_glyph(input logic [3:0] nib);
        case (nib)
            4'h0: hex_glyph = 8'h3F;
            4'h1: hex_glyph = 8'h06;
            4'h2: hex_glyph = 8'h5B;
            4'h3: hex_glyph = 8'h4F;
            4'h4: hex_glyph = 8'h66;
            4'h5: hex_glyph = 8'h6D;
            4'h6: hex_glyph = 8'h7D;
            4'h7: hex_glyph = 8'h07;
            4'h8: hex_glyph = 8'h7F;
            4'h9: hex_glyph = 8'h6F;
            4'hA: hex_glyph = 8'h77;
            4'hB: hex_glyph = 8'h7C;   // Lower case b
            4'hC: hex_glyph = 8'h39;
            4'hD: hex_glyph = 8'h5E;   // Lower case d
            4'hE: hex_glyph = 8'h79;
            default: hex_glyph = 8'h71;
        endcase
    endfunction

    // Most significant nibble goes to the leftmost digit
    always_comb begin
        for (int d = 0; d < W_TM_DIGIT; d++) begin
            o_seg[d] = hex_glyph(i_value[(W_TM_DIGIT - 1 - d) * 4 +: 4]);
        end
    end

endmodule

//--- key_tally.sv
`timescale 1ns/1ps

module key_tally (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  tm1638_pkg::tm_keys_t    i_keys,
    input  logic                    i_keys_valid,
    output tm1638_pkg::tm_display_t o_display
);
    import tm1638_pkg::*;

    tm_keys_t           keys_q;     // Key state of the last frame
    tm_keys_t           pressed;
    logic [W_TOTAL-1:0] total;
    logic [W_TOTAL-1:0] step;
    tm_seg_t            seg;

    // ------------------------------------------------
    // New presses and their weight

    always_comb begin
        pressed = i_keys & ~keys_q;
        step    = '0;
        // Key 7 belongs to the brightness control
        for (int k = 0; k < KEY_BRIGHT; k++) begin
            if (pressed[k])
                step = step + W_TOTAL'(k + 1);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            keys_q <= '0;
            total  <= '0;
        end else if (i_keys_valid) begin
            keys_q <= i_keys;
            total  <= total + step;     // Wraps through all ones
        end
    end

    // ------------------------------------------------
    // Panel image

    seg7_hex_encoder u_hex (
        .i_value ( total ),
        .o_seg   ( seg   )
    );

    assign o_display.seg = seg;
    assign o_display.led = keys_q;

endmodule

//--- board_top.sv
`timescale 1ns/1ps

module board_top (
    input  logic i_clk,
    input  logic i_rst_n,

    output logic o_tm_stb,
    output logic o_tm_clk,
    output logic o_tm_dio,
    output logic o_tm_dio_oe,
    input  logic i_tm_dio
);
    import tm1638_pkg::*;

    tm_display_t display;
    tm_cfg_t     cfg;
    tm_keys_t    keys;
    logic        keys_valid;

    // ------------------------------------------------
    // Lab logic

    key_tally u_key_tally (
        .i_clk        ( i_clk      ),
        .i_rst_n      ( i_rst_n    ),
        .i_keys       ( keys       ),
        .i_keys_valid ( keys_valid ),
        .o_display    ( display    )
    );

    tm1638_config u_config (
        .i_clk        ( i_clk      ),
        .i_rst_n      ( i_rst_n    ),
        .i_keys       ( keys       ),
        .i_keys_valid ( keys_valid ),
        .o_cfg        ( cfg        )
    );

    // ------------------------------------------------
    // Panel link

    tm1638_controller u_controller (
        .i_clk        ( i_clk       ),
        .i_rst_n      ( i_rst_n     ),
        .i_display    ( display     ),
        .i_cfg        ( cfg         ),
        .i_tm_dio     ( i_tm_dio    ),
        .o_keys       ( keys        ),
        .o_keys_valid ( keys_valid  ),
        .o_tm_stb     ( o_tm_stb    ),
        .o_tm_clk     ( o_tm_clk    ),
        .o_tm_dio     ( o_tm_dio    ),
        .o_tm_dio_oe  ( o_tm_dio_oe )
    );

endmodule

//--- tm1638_model.sv
`timescale 1ns/1ps

module tm1638_model (
    input  logic                                   i_tm_stb,
    input  logic                                   i_tm_clk,
    input  logic                                   i_tm_dio,
    input  logic                                   i_tm_dio_oe,
    input  tm1638_pkg::tm_keys_t                   i_keys,
    output logic                                   o_tm_dio,
    output logic [tm1638_pkg::N_DATA_BYTES-1:0][7:0] o_disp_bytes,
    output logic [7:0]                             o_disp_cmd,
    output logic [31:0]                            o_frames,
    output logic                                   o_fault,
    output logic [7:0]                             o_fault_got,
    output logic [7:0]                             o_fault_exp
);
    import tm1638_pkg::*;

    int         win;        // 0 mode, 1 data, 2 control, 3 keys
    int         bit_cnt;
    int         byte_cnt;
    logic [7:0] shift;
    logic       stb_q;
    logic       clk_q;
    tm_keys_t   pair;       // Key pair of the current read byte in bits 1:0

    // Bytes a window carries with the command included
    function automatic int window_len(input int w);
        case (w)
            1:       window_len = N_DATA_BYTES + 1;
            3:       window_len = N_KEY_BYTES + 1;
            default: window_len = 1;
        endcase
    endfunction

    function automatic logic [7:0] window_cmd(input int w, input logic [7:0] b);
        case (w)
            0:       window_cmd = CMD_WRITE_AUTO;
            1:       window_cmd = CMD_ADDR0;
            2:       window_cmd = CMD_DISPLAY | {5'b0, b[2:0]};    // Any brightness
            default: window_cmd = CMD_READ_KEYS;
        endcase
    endfunction

    task automatic report_fault(input string what, input logic [7:0] got,
                                input logic [7:0] exp);
        $display("Panel model: %s out of place in window %0d at byte %0d",
                 what, win, byte_cnt);
        o_fault_got = got;
        o_fault_exp = exp;
        o_fault     = 1'b1;
    endtask

    // ------------------------------------------------
    // Frame decoding

    task automatic take_byte(input logic [7:0] b);
        if (byte_cnt == 0) begin
            if (b !== window_cmd(win, b))
                report_fault("command byte", b, window_cmd(win, b));
            if (win == 2)
                o_disp_cmd = b;
        end else if (win == 1 && byte_cnt <= N_DATA_BYTES) begin
            o_disp_bytes[byte_cnt - 1] = b;
        end
    endtask

    task automatic close_window();
        if (bit_cnt != 0)
            report_fault("partial byte", 8'(bit_cnt), 8'h00);
        else if (byte_cnt != window_len(win))
            report_fault("window end", 8'(byte_cnt), 8'(window_len(win)));
        o_tm_dio = 1'b1;
        if (win == 3)
            o_frames = o_frames + 1;
        win = (win + 1) % 4;
    endtask

    // Panel puts the next read bit out while the clock is low
    task automatic drive_read_bit();
        if (win == 3 && byte_cnt > 0 && byte_cnt <= N_KEY_BYTES) begin
            pair = i_keys >> (2 * (byte_cnt - 1));
            case (bit_cnt)
                0:       o_tm_dio = pair[0];
                4:       o_tm_dio = pair[1];
                default: o_tm_dio = 1'b0;
            endcase
        end
    endtask

    initial begin
        win          = 0;
        bit_cnt      = 0;
        byte_cnt     = 0;
        shift        = '0;
        stb_q        = 1'b1;
        clk_q        = 1'b1;
        o_tm_dio     = 1'b1;     // Pull-up while nobody drives
        o_disp_bytes = '0;
        o_disp_cmd   = '0;
        o_frames     = '0;
        o_fault      = 1'b0;
        o_fault_got  = '0;
        o_fault_exp  = '0;
        forever begin
            @(i_tm_stb or i_tm_clk);
            if (i_tm_stb !== stb_q) begin
                stb_q = i_tm_stb;
                if (!i_tm_stb) begin
                    bit_cnt  = 0;
                    byte_cnt = 0;
                end else begin
                    close_window();
                end
            end else if (i_tm_clk !== clk_q) begin
                clk_q = i_tm_clk;
                if (!i_tm_stb && i_tm_clk) begin
                    shift = {i_tm_dio, shift[7:1]};     // LSB first
                    if (win == 3 && byte_cnt > 0) begin
                        if (i_tm_dio_oe)
                            report_fault("driven data line", 8'h01, 8'h00);
                    end else if (!i_tm_dio_oe) begin
                        report_fault("released data line", 8'h00, 8'h01);
                    end
                    bit_cnt = bit_cnt + 1;
                    if (bit_cnt == 8) begin
                        bit_cnt = 0;
                        take_byte(shift);
                        byte_cnt = byte_cnt + 1;
                    end
                end else if (!i_tm_stb) begin
                    drive_read_bit();
                end
            end
        end
    end

endmodule

//--- tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top;
    import tm1638_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       tm_stb;
    logic       tm_clk;
    logic       tm_dio_out;
    logic       tm_dio_oe;
    logic       tm_dio_in;
    tm_keys_t   key_pattern;

    logic [N_DATA_BYTES-1:0][7:0] disp_bytes;
    logic [7:0]  disp_cmd;
    logic [31:0] frames;
    logic        fault;
    logic [7:0]  fault_got;
    logic [7:0]  fault_exp;

    // One entry per line of the test file
    logic [7:0]  step_keys[$];
    logic [31:0] step_total[$];
    logic [7:0]  step_led[$];
    logic [3:0]  step_bright[$];
    longint      timeout_ns = 0;

    always #20 clk = ~clk;

    board_top UUT (
        .i_clk       ( clk        ),
        .i_rst_n     ( rst_n      ),
        .o_tm_stb    ( tm_stb     ),
        .o_tm_clk    ( tm_clk     ),
        .o_tm_dio    ( tm_dio_out ),
        .o_tm_dio_oe ( tm_dio_oe  ),
        .i_tm_dio    ( tm_dio_in  )
    );

    tm1638_model u_panel (
        .i_tm_stb     ( tm_stb      ),
        .i_tm_clk     ( tm_clk      ),
        .i_tm_dio     ( tm_dio_out  ),
        .i_tm_dio_oe  ( tm_dio_oe   ),
        .i_keys       ( key_pattern ),
        .o_tm_dio     ( tm_dio_in   ),
        .o_disp_bytes ( disp_bytes  ),
        .o_disp_cmd   ( disp_cmd    ),
        .o_frames     ( frames      ),
        .o_fault      ( fault       ),
        .o_fault_got  ( fault_got   ),
        .o_fault_exp  ( fault_exp   )
    );

    // ------------------------------------------------
    // Helpers

    // Common hex glyphs, segment a in bit 0, dot off
    function automatic logic [7:0] expected_glyph(input logic [3:0] nib);
        case (nib)
            4'h0: expected_glyph = 8'h3F;
            4'h1: expected_glyph = 8'h06;
            4'h2: expected_glyph = 8'h5B;
            4'h3: expected_glyph = 8'h4F;
            4'h4: expected_glyph = 8'h66;
            4'h5: expected_glyph = 8'h6D;
            4'h6: expected_glyph = 8'h7D;
            4'h7: expected_glyph = 8'h07;
            4'h8: expected_glyph = 8'h7F;
            4'h9: expected_glyph = 8'h6F;
            4'hA: expected_glyph = 8'h77;
            4'hB: expected_glyph = 8'h7C;
            4'hC: expected_glyph = 8'h39;
            4'hD: expected_glyph = 8'h5E;
            4'hE: expected_glyph = 8'h79;
            default: expected_glyph = 8'h71;
        endcase
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_frames(input int n);
        logic [31:0] target;
        target = frames + 32'(n);
        while (frames < target)
            @(negedge clk);
    endtask

    always @(posedge fault) begin
        check_value("frame_byte", fault_got, fault_exp);
    end

    // ------------------------------------------------
    // Watchdog

    initial begin : watchdog
        wait (timeout_ns != 0);
        #(timeout_ns);
        $display("Panel stopped framing, no end of test after %0d ns", timeout_ns);
        abort_run();
    end

    // ------------------------------------------------
    // Test steps

    initial begin : main
        int          fd;
        int          idle;
        logic [7:0]  keys_in;
        logic [31:0] total_in;
        logic [7:0]  led_in;
        logic [3:0]  bright_in;
        logic [31:0] exp_total;

        clk         = 1'b0;
        rst_n       = 1'b0;
        key_pattern = '0;
        void'($urandom(73718));     // Fixed seed for the idle frame choice

        fd = $fopen("board_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open board_tests.txt");
            abort_run();
        end
        while ($fscanf(fd, "%h %h %h %h", keys_in, total_in, led_in, bright_in) == 4) begin
            step_keys.push_back(keys_in);
            step_total.push_back(total_in);
            step_led.push_back(led_in);
            step_bright.push_back(bright_in);
        end
        $fclose(fd);
        if (step_keys.size() == 0) begin
            $display("No test steps found in board_tests.txt");
            abort_run();
        end

        // Six frames of at most 26 bytes per step, doubled for margin
        timeout_ns = longint'(step_keys.size()) * 6 * 26 * 16 * SIO_HALF_CYCLES * 40 * 2;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < step_keys.size(); i++) begin
            @(negedge clk);
            key_pattern = step_keys[i];
            idle        = int'($urandom % 3);
            wait_frames(3 + idle);      // Read, update, then shown in a full frame

            exp_total = step_total[i];
            for (int d = 0; d < W_TM_DIGIT; d++) begin
                check_value($sformatf("step %0d digit %0d segments", i, d),
                            disp_bytes[2 * d],
                            expected_glyph(exp_total[(W_TM_DIGIT - 1 - d) * 4 +: 4]));
                check_value($sformatf("step %0d led %0d byte", i, d),
                            disp_bytes[2 * d + 1], {7'b0, step_led[i][d]});
            end
            check_value($sformatf("step %0d display command", i), disp_cmd,
                        CMD_DISPLAY | {5'b0, step_bright[i][2:0]});
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- board_tests.txt
00 00000000 00 7
01 00000001 01 7
01 00000001 01 7
00 00000001 00 7
01 00000002 01 7
08 00000006 08 7
7F 0000001E 7F 7
00 0000001E 00 7
7F 0000003A 7F 7
80 0000003A 80 0
00 0000003A 00 0
80 0000003A 80 1
C0 00000041 C0 1
7F 00000056 7F 1
FF 00000056 FF 2
00 00000056 00 2
7F 00000072 7F 2
00 00000072 00 2
7F 0000008E 7F 2
00 0000008E 00 2
7F 000000AA 7F 2

//--- all.f
tm1638_pkg.sv
tm1638_serial.sv
tm1638_controller.sv
tm1638_config.sv
seg7_hex_encoder.sv
key_tally.sv
board_top.sv
tm1638_model.sv
tb_board_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_board_top
FILELIST = all.f
OBJ_DIR  = obj_dir

SOURCES  = $(shell cat $(FILELIST))
SIM_BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) board_tests.txt
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
